//--- rtl/base_ram.sv
// One wait state per access; contents are not cleared by reset and power up undefined
`timescale 1ns/1ps
`default_nettype none

module base_ram (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       stb_i,
  input  logic                       we_i,
  input  logic [soc_pkg::RAM_AW-1:0] adr_i,
  input  soc_pkg::sel_t              sel_i,
  input  soc_pkg::word_t             dat_i,
  output soc_pkg::word_t             dat_o,
  output logic                       ack_o
);

  soc_pkg::word_t mem [soc_pkg::RAM_WORDS];
  logic           access;

  // First strobe cycle only, the ack cycle is not a new transfer
  assign access = stb_i & ~ack_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  // Byte lane writes and registered read
  always_ff @(posedge clk) begin
    if (access) begin
      dat_o <= mem[adr_i];
      for (int b = 0; b < soc_pkg::SEL_W; b++) begin
        if (we_i && sel_i[b]) begin
          mem[adr_i][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/bus_decode.sv
// Purely combinational; the address must stay stable for the whole cycle, unmatched goes to default
`timescale 1ns/1ps
`default_nettype none

module bus_decode (
  input  logic           cyc_i,
  input  logic           stb_i,
  input  logic           tga_i,
  input  soc_pkg::adr_t  adr_i,
  output logic           ram_stb_o,
  output logic           gpio_stb_o,
  output logic           def_stb_o,
  output soc_pkg::tgt_t  tgt_o
);

  logic [soc_pkg::ADR_W:0] full_adr;  // Tag in the top bit
  logic                    ram_hit;
  logic                    gpio_hit;
  logic                    req;

  assign full_adr = {tga_i, adr_i};
  assign req      = cyc_i & stb_i;

  // Address/mask match per window
  assign ram_hit  = (full_adr & soc_pkg::RAM_MASK) == soc_pkg::RAM_ADDR;
  assign gpio_hit = (full_adr & soc_pkg::GPIO_MASK) == soc_pkg::GPIO_ADDR;

  // Windows do not overlap, RAM is checked first anyway
  always_comb begin
    tgt_o = '0;
    if (ram_hit) begin
      tgt_o[soc_pkg::TGT_RAM] = 1'b1;
    end else if (gpio_hit) begin
      tgt_o[soc_pkg::TGT_GPIO] = 1'b1;
    end else begin
      tgt_o[soc_pkg::TGT_DEF] = 1'b1;  // Everything else
    end
  end

  // One strobe per target, only inside a bus cycle
  assign ram_stb_o  = req & tgt_o[soc_pkg::TGT_RAM];
  assign gpio_stb_o = req & tgt_o[soc_pkg::TGT_GPIO];
  assign def_stb_o  = req & tgt_o[soc_pkg::TGT_DEF];

endmodule

`default_nettype wire

//--- rtl/bus_response.sv
// Slaves must keep data stable in their ack cycle; NMI acknowledge wins over INT acknowledge
`timescale 1ns/1ps
`default_nettype none

module bus_response (
  input  logic           clk,
  input  logic           rst,
  input  logic           def_stb_i,
  input  soc_pkg::tgt_t  tgt_i,
  input  logic           ram_ack_i,
  input  logic           gpio_ack_i,
  input  soc_pkg::word_t ram_dat_i,
  input  soc_pkg::word_t gpio_dat_i,
  input  logic           inta_i,
  input  logic           nmia_i,
  input  soc_pkg::iid_t  iid_i,
  output logic           ack_o,
  output soc_pkg::word_t dat_o
);

  logic           def_ack;
  soc_pkg::word_t slave_dat;

  // Default responder, same wait state as the real slaves
  always_ff @(posedge clk) begin
    if (rst) begin
      def_ack <= 1'b0;
    end else begin
      def_ack <= def_stb_i & ~def_ack;
    end
  end

  assign ack_o = ram_ack_i | gpio_ack_i | def_ack;

  always_comb begin
    if (tgt_i[soc_pkg::TGT_RAM]) begin
      slave_dat = ram_dat_i;
    end else if (tgt_i[soc_pkg::TGT_GPIO]) begin
      slave_dat = gpio_dat_i;
    end else begin
      slave_dat = soc_pkg::DEFAULT_DATA;  // Default target
    end
  end

  // Vector override while the master acknowledges
  always_comb begin
    if (nmia_i) begin
      dat_o = soc_pkg::NMI_VECTOR;
    end else if (inta_i) begin
      dat_o = soc_pkg::INT_VECTOR_BASE + soc_pkg::word_t'(iid_i);
    end else begin
      dat_o = slave_dat;
    end
  end

endmodule

`default_nettype wire

//--- rtl/gpio_regs.sv
// Keys are active low and pass two sync flops; reg 0 is read only, reg 1 holds LED_W LED bits
`timescale 1ns/1ps
`default_nettype none

module gpio_regs (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      stb_i,
  input  logic                      we_i,
  input  logic                      reg_sel_i,  // Address bit 1
  input  soc_pkg::sel_t             sel_i,
  input  soc_pkg::word_t            dat_i,
  output soc_pkg::word_t            dat_o,
  output logic                      ack_o,
  input  logic [9:0]                sw_i,
  input  logic [3:0]                key_i,
  output logic [soc_pkg::LED_W-1:0] led_o,
  input  logic                      nmia_i,
  output logic                      nmi_o
);

  logic [3:0] key_s1;
  logic [3:0] key_s2;
  logic       nmi_key_d;  // Previous synchronized NMI key level
  logic       access;
  logic       press;

  assign access = stb_i & ~ack_o;
  assign press  = nmi_key_d & ~key_s2[soc_pkg::NMI_KEY];  // Falling edge, key pushed

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_o     <= 1'b0;
      key_s1    <= '1;  // Released
      key_s2    <= '1;
      nmi_key_d <= 1'b1;
      led_o     <= '0;
      nmi_o     <= 1'b0;
    end else begin
      ack_o     <= access;
      key_s1    <= key_i;
      key_s2    <= key_s1;
      nmi_key_d <= key_s2[soc_pkg::NMI_KEY];
      nmi_o     <= (nmi_o & ~nmia_i) | press;  // New press beats the acknowledge
      if (access && we_i && reg_sel_i) begin
        if (sel_i[0]) led_o[7:0] <= dat_i[7:0];
        if (sel_i[1]) led_o[soc_pkg::LED_W-1:8] <= dat_i[soc_pkg::LED_W-1:8];
      end
    end
  end

  // Read data for the ack cycle
  always_ff @(posedge clk) begin
    if (access) begin
      if (reg_sel_i) begin
        dat_o <= {{(soc_pkg::DAT_W - soc_pkg::LED_W){1'b0}}, led_o};
      end else begin
        dat_o <= {key_s2, 2'b00, sw_i};
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/int_ctrl.sv
// Lines are edge triggered and latched; line 0 has the highest priority, no masking
`timescale 1ns/1ps
`default_nettype none

module int_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [soc_pkg::IRQ_N-1:0] irq_i,
  input  logic                      inta_i,
  output logic                      intr_o,
  output soc_pkg::iid_t             iid_o
);

  logic [soc_pkg::IRQ_N-1:0] irq_prev;
  logic [soc_pkg::IRQ_N-1:0] pending;
  logic [soc_pkg::IRQ_N-1:0] rise;
  logic [soc_pkg::IRQ_N-1:0] clr;

  assign rise = irq_i & ~irq_prev;

  // Sampled through reset too, so a line held high gives no edge afterwards
  always_ff @(posedge clk) begin
    irq_prev <= irq_i;
  end

  // Acknowledge retires the line that is being served
  always_comb begin
    clr = '0;
    if (inta_i) begin
      clr[iid_o] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      pending <= (pending & ~clr) | rise;  // Fresh edge is kept
    end
  end

  // Lowest pending index wins
  always_comb begin
    iid_o = '0;
    for (int i = soc_pkg::IRQ_N - 1; i >= 0; i--) begin
      if (pending[i]) begin
        iid_o = soc_pkg::iid_t'(i);
      end
    end
  end

  assign intr_o = |pending;

endmodule

`default_nettype wire

//--- rtl/reset_stretch.sv
// Inputs are sampled on clk; power-up relies on the counter's initial value being loaded
`timescale 1ns/1ps
`default_nettype none

module reset_stretch (
  input  logic clk,
  input  logic rst_lck,   // Active low
  input  logic force_i,   // Switch forced reset
  output logic rst_o
);

  localparam int CNT_W = $clog2(soc_pkg::RST_HOLD_CYCLES + 1);

  // Starts loaded so the core comes up in reset
  logic [CNT_W-1:0] hold_cnt = CNT_W'(soc_pkg::RST_HOLD_CYCLES);

  always_ff @(posedge clk) begin
    if (!rst_lck || force_i) begin
      hold_cnt <= CNT_W'(soc_pkg::RST_HOLD_CYCLES);  // Reload while held
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  assign rst_o = hold_cnt != '0;

endmodule

`default_nettype wire

//--- rtl/soc_core.sv
// Single clock Wishbone classic core; inta_i and nmia_i must pulse outside bus cycles
`timescale 1ns/1ps
`default_nettype none

module soc_core (
  input  logic                      clk,
  input  logic                      rst_lck,
  input  logic                      wb_cyc_i,
  input  logic                      wb_stb_i,
  input  logic                      wb_we_i,
  input  logic                      wb_tga_i,
  input  soc_pkg::adr_t             wb_adr_i,
  input  soc_pkg::sel_t             wb_sel_i,
  input  soc_pkg::word_t            wb_dat_i,
  output soc_pkg::word_t            wb_dat_o,
  output logic                      wb_ack_o,
  input  logic [soc_pkg::IRQ_N-1:0] irq_i,
  output logic                      intr_o,
  output soc_pkg::iid_t             iid_o,
  input  logic                      inta_i,
  input  logic                      nmia_i,
  output logic                      nmi_o,
  input  logic [9:0]                sw_i,
  input  logic [3:0]                key_i,
  output logic [soc_pkg::LED_W-1:0] led_o
);

  logic           rst;
  logic           ram_stb;
  logic           gpio_stb;
  logic           def_stb;
  soc_pkg::tgt_t  tgt;
  logic           ram_ack;
  logic           gpio_ack;
  soc_pkg::word_t ram_dat;
  soc_pkg::word_t gpio_dat;

  // Switch 0 doubles as a reset button
  reset_stretch u_rst (
    .clk(clk), .rst_lck(rst_lck), .force_i(sw_i[0]), .rst_o(rst)
  );

  bus_decode u_decode (
    .cyc_i(wb_cyc_i), .stb_i(wb_stb_i), .tga_i(wb_tga_i), .adr_i(wb_adr_i),
    .ram_stb_o(ram_stb), .gpio_stb_o(gpio_stb), .def_stb_o(def_stb), .tgt_o(tgt)
  );

  base_ram u_ram (
    .clk(clk), .rst(rst), .stb_i(ram_stb), .we_i(wb_we_i),
    .adr_i(wb_adr_i[soc_pkg::RAM_AW:1]), .sel_i(wb_sel_i), .dat_i(wb_dat_i),
    .dat_o(ram_dat), .ack_o(ram_ack)
  );

  gpio_regs u_gpio (
    .clk(clk), .rst(rst), .stb_i(gpio_stb), .we_i(wb_we_i), .reg_sel_i(wb_adr_i[1]),
    .sel_i(wb_sel_i), .dat_i(wb_dat_i), .dat_o(gpio_dat), .ack_o(gpio_ack),
    .sw_i(sw_i), .key_i(key_i), .led_o(led_o), .nmia_i(nmia_i), .nmi_o(nmi_o)
  );

  int_ctrl u_pic (
    .clk(clk), .rst(rst), .irq_i(irq_i), .inta_i(inta_i), .intr_o(intr_o), .iid_o(iid_o)
  );

  // Merges acks and applies the vector override
  bus_response u_resp (
    .clk(clk), .rst(rst), .def_stb_i(def_stb), .tgt_i(tgt),
    .ram_ack_i(ram_ack), .gpio_ack_i(gpio_ack), .ram_dat_i(ram_dat), .gpio_dat_i(gpio_dat),
    .inta_i(inta_i), .nmia_i(nmia_i), .iid_i(iid_o), .ack_o(wb_ack_o), .dat_o(wb_dat_o)
  );

endmodule

`default_nettype wire

//--- rtl/soc_pkg.sv
// Assumes a 16-bit Wishbone bus with two byte selects and a 20-bit {tga, adr[19:1]} space
`default_nettype none

package soc_pkg;

  // Bus geometry
  localparam int ADR_W = 19;
  localparam int DAT_W = 16;
  localparam int SEL_W = 2;
  localparam int IRQ_N = 8;

  typedef logic [ADR_W:1]           adr_t;  // Word address, byte bit 0 is implied by sel
  typedef logic [DAT_W-1:0]         word_t;
  typedef logic [SEL_W-1:0]         sel_t;
  typedef logic [$clog2(IRQ_N)-1:0] iid_t;
  typedef logic [2:0]               tgt_t;

  // Bit positions inside tgt_t
  localparam int TGT_RAM  = 0;
  localparam int TGT_GPIO = 1;
  localparam int TGT_DEF  = 2;

  // Decode windows, compared against {tga, adr[19:1]}
  // Memory 0x00000 - 0x003ff
  localparam logic [ADR_W:0] RAM_ADDR  = 20'h00000;
  localparam logic [ADR_W:0] RAM_MASK  = 20'hFFE00;
  // I/O 0xf100 - 0xf103
  localparam logic [ADR_W:0] GPIO_ADDR = 20'h87880;
  localparam logic [ADR_W:0] GPIO_MASK = 20'hFFFFE;

  // Base RAM size
  localparam int RAM_WORDS = 512;
  localparam int RAM_AW    = 9;

  // Fixed response values
  localparam logic [DAT_W-1:0] DEFAULT_DATA    = 16'hFFFF; // Unmapped reads
  localparam logic [DAT_W-1:0] NMI_VECTOR      = 16'h0002;
  localparam logic [DAT_W-1:0] INT_VECTOR_BASE = 16'h0008; // Plus iid

  // Reset stretch length in clk cycles after release
  localparam int RST_HOLD_CYCLES = 16;

  // Pushbutton that raises the NMI
  localparam int NMI_KEY = 3;

  // Width of the LED register
  localparam int LED_W = 14;

endpackage

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert --top-module soc_core_tb -f soc_core.f -o soc_core_sim
if ! ./obj_dir/soc_core_sim > sim.log 2>&1; then
  cat sim.log
  echo "Simulation exited with an error"
  exit 1
fi
cat sim.log
if grep -q "Test FAILED" sim.log; then
  exit 1
fi
grep -q "Test OK" sim.log

//--- soc_core.f
rtl/soc_pkg.sv
rtl/bus_decode.sv
rtl/base_ram.sv
rtl/gpio_regs.sv
rtl/int_ctrl.sv
rtl/bus_response.sv
rtl/reset_stretch.sv
rtl/soc_core.sv
tests/soc_core_sva.sv
tests/soc_core_tb.sv

//--- tests/soc_core_sva.sv
// Bus and interrupt protocol rules checked on the core's own clock edge
`timescale 1ns/1ps
`default_nettype none

module soc_core_sva (
  input logic                      clk,
  input logic                      rst_i,
  input logic                      wb_cyc_i,
  input logic                      wb_stb_i,
  input logic                      wb_ack_i,
  input logic                      intr_i,
  input logic [soc_pkg::IRQ_N-1:0] irq_i
);

  ack_after_req: assert property (@(posedge clk) wb_ack_i |-> $past(wb_cyc_i && wb_stb_i))
    else $error("wb_ack_o without a request in the previous cycle");

  ack_single: assert property (@(posedge clk) !(wb_ack_i && $past(wb_ack_i)))
    else $error("wb_ack_o high for two cycles in a row");

  // Slaves are held quiet during reset
  no_ack_in_rst: assert property (@(posedge clk) rst_i |-> !wb_ack_i)
    else $error("wb_ack_o high while the internal reset is active");

  // Nothing becomes pending without a fresh rising edge on a line
  intr_needs_edge: assert property (@(posedge clk)
    $rose(intr_i) |-> |($past(irq_i) & ~$past(irq_i, 2)))
    else $error("intr_o rose with no rising edge on irq_i");

endmodule

bind soc_core soc_core_sva u_sva (
  .clk(clk), .rst_i(rst), .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i),
  .wb_ack_i(wb_ack_o), .intr_i(intr_o), .irq_i(irq_i)
);

`default_nettype wire

//--- tests/soc_core_tb.sv
// Random master with seed 39; sw_i[0] stays low except in the reset test, key 3 idles released
`timescale 1ns/1ps
`default_nettype none

module soc_core_tb;

  localparam int BUS_TIMEOUT = 50;
  localparam int EVT_TIMEOUT = 20;
  localparam int RST_TIMEOUT = 200;

  logic                      clk = 1'b0;
  logic                      rst_lck;
  logic                      cyc, stb, we, tga;
  soc_pkg::adr_t             adr;
  soc_pkg::sel_t             sel;
  soc_pkg::word_t            wdat, rdat, q;
  logic                      ack, intr, inta, nmia, nmi;
  logic [soc_pkg::IRQ_N-1:0] irq, nv, irq_prev_m, pend_m;
  soc_pkg::iid_t             iid;
  logic [9:0]                sw;
  logic [3:0]                key;
  logic [soc_pkg::LED_W-1:0] led, led_m;
  soc_pkg::word_t            ram_m [int];
  int                        errors = 0, checks = 0, timeouts = 0;

  always #4 clk = ~clk;

  soc_core u_dut (
    .clk(clk), .rst_lck(rst_lck), .wb_cyc_i(cyc), .wb_stb_i(stb), .wb_we_i(we),
    .wb_tga_i(tga), .wb_adr_i(adr), .wb_sel_i(sel), .wb_dat_i(wdat), .wb_dat_o(rdat),
    .wb_ack_o(ack), .irq_i(irq), .intr_o(intr), .iid_o(iid), .inta_i(inta),
    .nmia_i(nmia), .nmi_o(nmi), .sw_i(sw), .key_i(key), .led_o(led)
  );

  task automatic check_word(input string name, input soc_pkg::word_t exp,
                            input soc_pkg::word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_iid(input string name, input soc_pkg::iid_t exp,
                           input soc_pkg::iid_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %0d actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("ERR %s expected %b actual %b", name, exp, act);
    end
  endtask

  // Line 0 is served first
  function automatic soc_pkg::iid_t lowest(input logic [soc_pkg::IRQ_N-1:0] p);
    for (int i = 0; i < soc_pkg::IRQ_N; i++) begin
      if (p[i]) return soc_pkg::iid_t'(i);
    end
    return '0;
  endfunction

  // One classic cycle with data sampled at the falling edge of the ack cycle
  task automatic bus_xfer(input logic w, input logic t, input soc_pkg::adr_t a,
                          input soc_pkg::sel_t s, input soc_pkg::word_t d,
                          output soc_pkg::word_t rd);
    int n;
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we <= w;
    tga <= t;
    adr <= a;
    sel <= s;
    wdat <= d;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ack && n < BUS_TIMEOUT);
    rd = rdat;
    if (!ack) begin
      timeouts++;
      $display("No ack from the bus for address %h", {t, a});
    end
    check_bit("ack_delay", 1'b1, n == 2);  // Ack one cycle after the first strobe cycle
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    we <= 1'b0;
  endtask

  task automatic int_ack();
    soc_pkg::iid_t low;
    low = lowest(pend_m);
    @(posedge clk);
    inta <= 1'b1;
    @(negedge clk);
    check_word("int_vector", soc_pkg::INT_VECTOR_BASE + soc_pkg::word_t'(low), rdat);
    check_iid("int_iid", low, iid);
    @(posedge clk);
    inta <= 1'b0;
    pend_m[low] = 1'b0;
  endtask

  task automatic press_nmi_key();
    int n;
    repeat (4) @(posedge clk);
    key[soc_pkg::NMI_KEY] <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!nmi && n < EVT_TIMEOUT);
    if (!nmi) begin
      timeouts++;
      $display("nmi_o did not rise after the key press");
    end
    @(posedge clk);
    key[soc_pkg::NMI_KEY] <= 1'b1;  // Released again
  endtask

  initial begin
    int n;
    soc_pkg::adr_t a;
    soc_pkg::sel_t s;
    soc_pkg::word_t d, exp;
    void'($urandom(39));
    rst_lck = 1'b0;
    {cyc, stb, we, tga, inta, nmia} = '0;
    adr = '0;
    sel = '0;
    wdat = '0;
    irq = '0;
    sw = '0;
    key = 4'hF;
    irq_prev_m = '0;
    pend_m = '0;
    led_m = '0;
    repeat (3) @(posedge clk);
    rst_lck <= 1'b1;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (u_dut.rst && n < RST_TIMEOUT);
    if (u_dut.rst) begin
      timeouts++;
      $display("Internal reset never released");
    end

    // RAM with byte merging
    for (int i = 0; i < 300; i++) begin
      a = soc_pkg::adr_t'($urandom % soc_pkg::RAM_WORDS);
      if (!ram_m.exists(int'(a)) || ($urandom % 2) == 0) begin
        s = soc_pkg::sel_t'($urandom);
        d = soc_pkg::word_t'($urandom);
        if (!ram_m.exists(int'(a))) begin
          s = 2'b11;
          ram_m[int'(a)] = '0;
        end
        if (s[0]) ram_m[int'(a)][7:0] = d[7:0];
        if (s[1]) ram_m[int'(a)][15:8] = d[15:8];
        bus_xfer(1'b1, 1'b0, a, s, d, q);
      end else begin
        bus_xfer(1'b0, 1'b0, a, 2'b11, '0, q);
        check_word("ram_read", ram_m[int'(a)], q);
      end
    end

    // Unmapped memory and I/O
    for (int i = 0; i < 40; i++) begin
      a = soc_pkg::adr_t'($urandom) | 19'h200;
      bus_xfer(1'b1, 1'b0, a, 2'b11, soc_pkg::word_t'($urandom), q);
      bus_xfer(1'b0, 1'b0, a, 2'b11, '0, q);
      check_word("unmapped_mem", soc_pkg::DEFAULT_DATA, q);
      a = soc_pkg::adr_t'($urandom);
      if (a[soc_pkg::ADR_W:2] == 18'h3C40) a = a ^ 19'h100;  // Skip the GPIO pair
      bus_xfer(1'b1, 1'b1, a, 2'b11, soc_pkg::word_t'($urandom), q);
      bus_xfer(1'b0, 1'b1, a, 2'b11, '0, q);
      check_word("unmapped_io", soc_pkg::DEFAULT_DATA, q);
    end
    n = 0;
    foreach (ram_m[k]) begin
      if (n < 20) begin
        bus_xfer(1'b0, 1'b0, soc_pkg::adr_t'(k), 2'b11, '0, q);
        check_word("ram_kept", ram_m[k], q);
      end
      n++;
    end

    // GPIO registers
    for (int i = 0; i < 20; i++) begin
      @(posedge clk);
      sw <= {9'($urandom), 1'b0};
      key <= {1'b1, 3'($urandom)};
      repeat (3) @(posedge clk);  // Two sync flops
      bus_xfer(1'b0, 1'b1, 19'h7880, 2'b11, '0, q);
      check_word("gpio_inputs", {key, 2'b00, sw}, q);
      s = soc_pkg::sel_t'($urandom);
      d = soc_pkg::word_t'($urandom);
      if (s[0]) led_m[7:0] = d[7:0];
      if (s[1]) led_m[soc_pkg::LED_W-1:8] = d[soc_pkg::LED_W-1:8];
      bus_xfer(1'b1, 1'b1, 19'h7881, s, d, q);
      bus_xfer(1'b0, 1'b1, 19'h7881, 2'b11, '0, q);
      check_word("gpio_led_reg", soc_pkg::word_t'(led_m), q);
      check_word("gpio_led_pins", soc_pkg::word_t'(led_m), soc_pkg::word_t'(led));
    end

    // Interrupt edges show up one cycle after the drive edge
    for (int i = 0; i < 100; i++) begin
      nv = soc_pkg::IRQ_N'($urandom);
      @(posedge clk);
      irq <= nv;
      pend_m = pend_m | (nv & ~irq_prev_m);
      irq_prev_m = nv;
      @(posedge clk);
      @(negedge clk);
      check_bit("intr_level", |pend_m, intr);
      if (pend_m != '0 && ($urandom % 2) == 0) int_ack();
    end
    while (pend_m != '0) int_ack();
    @(negedge clk);
    check_bit("intr_drained", 1'b0, intr);

    // NMI alone and then together with inta
    press_nmi_key();
    @(posedge clk);
    nmia <= 1'b1;
    @(negedge clk);
    check_word("nmi_vector", soc_pkg::NMI_VECTOR, rdat);
    @(posedge clk);
    nmia <= 1'b0;
    @(negedge clk);
    check_bit("nmi_cleared", 1'b0, nmi);
    press_nmi_key();
    @(posedge clk);
    nmia <= 1'b1;
    inta <= 1'b1;
    @(negedge clk);
    check_word("nmi_over_int", soc_pkg::NMI_VECTOR, rdat);
    @(posedge clk);
    nmia <= 1'b0;
    inta <= 1'b0;
    @(negedge clk);
    check_bit("nmi_cleared_both", 1'b0, nmi);

    // Reset forced by the switch
    bus_xfer(1'b1, 1'b1, 19'h7881, 2'b11, 16'h2A5A, q);
    @(posedge clk);
    irq <= '0;  // Line 4 low first so the next drive is a rising edge
    @(posedge clk);
    irq <= 8'h10;
    @(posedge clk);
    @(negedge clk);
    check_bit("intr_before_force", 1'b1, intr);
    @(posedge clk);
    sw[0] <= 1'b1;
    @(posedge clk);
    cyc <= 1'b1;
    stb <= 1'b1;
    we <= 1'b0;
    tga <= 1'b0;
    adr <= '0;
    sel <= 2'b11;
    repeat (5) @(posedge clk);
    sw[0] <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!ack && n < RST_TIMEOUT);
    if (!ack) begin
      timeouts++;
      $display("No ack after the forced reset was released");
    end
    check_bit("ack_held_off", 1'b1, n >= soc_pkg::RST_HOLD_CYCLES);
    @(posedge clk);
    cyc <= 1'b0;
    stb <= 1'b0;
    @(negedge clk);
    check_word("led_after_reset", '0, soc_pkg::word_t'(led));
    check_bit("intr_after_reset", 1'b0, intr);

    $display("checks=%0d errors=%0d timeouts=%0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
